//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module uart_tb \
  && ./obj_dir/Vuart_tb | tee /dev/stderr | grep -q "^TESTS PASSED$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- verif/uart_tb.sv
`include "uart_defs.svh"

module uart_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS      = 20;
  localparam int NUM_CMDS  = 27;
  localparam int HOLD_CLKS = 8;
  localparam int WATCHDOG_CLKS = NUM_CMDS * (2 * `UART_FRAME_BITS + `UART_GAP_BITS +
                                 `UART_RESP_TIMEOUT_BITS + 3) * CLKS * 2;

  logic                        clk;
  logic                        rst_n;
  logic [`UART_CMD_WIDTH-1:0]  cmd_in;
  logic                        cmd_vld;
  logic                        cmd_rdy;
  logic                        tx;
  logic                        rx;
  logic [`UART_DATA_WIDTH-1:0] read_data;
  logic                        read_rdy;
  logic                        read_err;

  int value_errs = 0;
  int other_errs = 0;
  int frames_seen = 0;
  int cycle = 0;

  logic [15:0]    lfsr;
  logic [7:0]     ref_regs [128];
  logic [7:0]     dev_regs [128];
  uart_pkg::cmd_t sent_cmds [$];
  logic [6:0]     read_q [$];

  logic [7:0] reply_byte;
  logic       reply_bad_par;
  event       reply_ev;

  uart #(
    .CLKS_PER_BIT (CLKS)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] ref_read(input logic [6:0] addr);
    return ref_regs[addr];
  endfunction

  task automatic take_bits(input int n, output logic [7:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++)
    begin
      bits = {bits[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Samples one frame from tx and is entered on the first low sample of the start bit
  task automatic recv_frame(output logic [7:0] data, output logic par, output logic stop,
                            output logic start_ok);
    int i;
    repeat (CLKS / 2) @(negedge clk);
    start_ok = !tx;
    for (i = 0; i < 8; i++)
    begin
      repeat (CLKS) @(negedge clk);
      data[i] = tx;
    end
    repeat (CLKS) @(negedge clk);
    par = tx;
    repeat (CLKS) @(negedge clk);
    stop = tx;
  endtask

  task automatic run_command(input uart_pkg::cmd_t c);
    int frames_before;
    int accept_cyc;
    int n;
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    frames_before = frames_seen;
    accept_cyc = cycle;
    sent_cmds.push_back(c);
    if (c.write)
      ref_regs[c.addr] = c.data;
    else
      read_q.push_back(c.addr);
    // The command transfers on this edge while cmd_vld stays up a while longer
    @(posedge clk);
    for (n = 0; n < HOLD_CLKS; n++)
    begin
      @(negedge clk);
      if (cmd_rdy)
      begin
        $display("cmd_rdy rose right after a command was accepted");
        other_errs++;
      end
    end
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    if (c.write)
    begin
      while (!cmd_rdy)
        @(negedge clk);
      if (frames_seen != frames_before + 2)
      begin
        $display("cmd_rdy returned before both frames of a write were sent");
        other_errs++;
      end
    end
    else
    begin
      while (!read_rdy)
      begin
        if (cmd_rdy)
        begin
          $display("cmd_rdy went high while a read was still waiting for its reply");
          other_errs++;
        end
        @(negedge clk);
      end
      // A silent device can only be reported once the reply window has run out
      if ((c.addr == 7'h7E) &&
          (cycle - accept_cyc < (`UART_FRAME_BITS + `UART_RESP_TIMEOUT_BITS) * CLKS))
      begin
        $display("read_rdy for the silent address came before the reply timeout");
        other_errs++;
      end
      @(negedge clk);
      if (!cmd_rdy)
      begin
        $display("cmd_rdy did not return the cycle after read_rdy");
        other_errs++;
      end
    end
  endtask

  // The remote device decodes frames on tx and keeps its own registers
  initial
  begin : tx_monitor
    logic [7:0]     data;
    logic           par;
    logic           stop;
    logic           start_ok;
    logic           in_write;
    logic [6:0]     waddr;
    logic [7:0]     wdata;
    int             start_cyc;
    int             addr_start;
    int             gap;
    int             a;
    uart_pkg::cmd_t c;
    for (a = 0; a < 128; a++)
      dev_regs[a] = 8'(a) ^ 8'h5A;
    in_write = 1'b0;
    wait (rst_n);
    forever
    begin
      @(negedge clk);
      while (tx)
        @(negedge clk);
      start_cyc = cycle;
      recv_frame(data, par, stop, start_ok);
      frames_seen++;
      if (!start_ok || !stop)
      begin
        $display("A frame on tx had a broken start or stop bit");
        other_errs++;
      end
      if (par != ^data)
      begin
        $display("ERROR tx parity: got 0x%0h expected 0x%0h", par, ^data);
        value_errs++;
      end
      if (in_write)
      begin
        in_write = 1'b0;
        if (data != wdata)
        begin
          $display("ERROR tx data frame: got 0x%0h expected 0x%0h", data, wdata);
          value_errs++;
        end
        gap = start_cyc - addr_start - `UART_FRAME_BITS * CLKS;
        if (gap != `UART_GAP_BITS * CLKS)
        begin
          $display("ERROR tx gap: got 0x%0h expected 0x%0h", gap, `UART_GAP_BITS * CLKS);
          value_errs++;
        end
        dev_regs[waddr] = data;
      end
      else if (sent_cmds.size() == 0)
      begin
        $display("A frame appeared on tx with no command issued");
        other_errs++;
      end
      else
      begin
        c = sent_cmds.pop_front();
        if (data != {c.write, c.addr})
        begin
          $display("ERROR tx addr frame: got 0x%0h expected 0x%0h", data, {c.write, c.addr});
          value_errs++;
        end
        if (data[7])
        begin
          in_write   = 1'b1;
          waddr      = data[6:0];
          wdata      = c.data;
          addr_start = start_cyc;
        end
        else if (data[6:0] != 7'h7E)
        begin
          reply_byte    = dev_regs[data[6:0]];
          reply_bad_par = (data[6:0] == 7'h7F);
          -> reply_ev;
        end
      end
    end
  end

  initial
  begin : reply_driver
    logic [10:0] bits;
    int          i;
    rx <= 1'b1;
    forever
    begin
      @(reply_ev);
      bits = {1'b1, (^reply_byte) ^ reply_bad_par, reply_byte, 1'b0};
      repeat (3 * CLKS) @(posedge clk);
      for (i = 0; i < `UART_FRAME_BITS; i++)
      begin
        rx <= bits[i];
        repeat (CLKS) @(posedge clk);
      end
    end
  end

  // Compares every read result with the reference registers
  always @(negedge clk)
  begin : read_checker
    logic [6:0] addr;
    if (rst_n && read_rdy)
    begin
      if (read_q.size() == 0)
      begin
        $display("read_rdy pulsed with no read outstanding");
        other_errs++;
      end
      else
      begin
        addr = read_q.pop_front();
        if ((addr == 7'h7E) || (addr == 7'h7F))
        begin
          if (read_err !== 1'b1)
          begin
            $display("ERROR read_err: got 0x%0h expected 0x1 (addr 0x%0h)", read_err, addr);
            value_errs++;
          end
        end
        else
        begin
          if (read_err !== 1'b0)
          begin
            $display("ERROR read_err: got 0x%0h expected 0x0 (addr 0x%0h)", read_err, addr);
            value_errs++;
          end
          if (read_data !== ref_read(addr))
          begin
            $display("ERROR read_data: got 0x%0h expected 0x%0h (addr 0x%0h)",
                     read_data, ref_read(addr), addr);
            value_errs++;
          end
        end
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CLKS) @(posedge clk);
    $display("Watchdog expired before all commands had finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin : stimulus
    uart_pkg::cmd_t c;
    logic [7:0]     bits;
    int             i;
    lfsr = 16'd33;
    rst_n   <= 1'b0;
    cmd_vld <= 1'b0;
    cmd_in  <= '0;
    for (i = 0; i < 128; i++)
      ref_regs[i] = 8'(i) ^ 8'h5A;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if ((tx !== 1'b1) || (cmd_rdy !== 1'b1) || (read_rdy !== 1'b0) ||
        (read_err !== 1'b0))
    begin
      $display("Outputs after reset were not idle");
      other_errs++;
    end
    for (i = 0; i < NUM_CMDS; i++)
    begin
      // A few fixed reads cover the reset value, the silent device and a bad parity
      if (i == 0)
        c = {1'b0, 7'h42, 8'h00};
      else if (i == 9)
        c = {1'b0, 7'h7E, 8'h00};
      else if (i == 18)
        c = {1'b0, 7'h7F, 8'h00};
      else
      begin
        take_bits(1, bits);
        c.write = bits[0];
        take_bits(3, bits);
        c.addr = {4'h1, bits[2:0]};
        take_bits(8, bits);
        c.data = bits;
      end
      run_command(c);
    end
    repeat (5) @(negedge clk);
    if ((read_q.size() != 0) || (sent_cmds.size() != 0))
    begin
      $display("Some commands never produced their frames or results");
      other_errs++;
    end
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0))
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_rx_if.sv
verilog/uart_cmd_sequencer.sv
verilog/uart_tx_serializer.sv
verilog/uart_rx_deserializer.sv
verilog/uart.sv
verif/uart_tb.sv

//--- verilog/uart.sv
`include "uart_defs.svh"

module uart #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_CMD_WIDTH-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        tx,
  input  logic                        rx,
  output logic [`UART_DATA_WIDTH-1:0] read_data,
  output logic                        read_rdy,
  output logic                        read_err
);

  logic [`UART_DATA_WIDTH-1:0] tx_byte;
  logic                        tx_valid;
  logic                        tx_ready;

  uart_rx_if rxl ();

  // Orders the frames of one command and collects the read reply
  uart_cmd_sequencer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rxl       (rxl.seq),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_serializer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_rx_deserializer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .rxl   (rxl.rcv)
  );

endmodule

//--- verilog/uart_cmd_sequencer.sv
`include "uart_defs.svh"

module uart_cmd_sequencer #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_CMD_WIDTH-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic [`UART_DATA_WIDTH-1:0] tx_byte,
  output logic                        tx_valid,
  input  logic                        tx_ready,
  uart_rx_if.seq                      rxl,
  output logic [`UART_DATA_WIDTH-1:0] read_data,
  output logic                        read_rdy,
  output logic                        read_err
);

  localparam int GAP_CLKS = `UART_GAP_BITS * CLKS_PER_BIT;
  // The reply is only seen once its stop bit is sampled, so a whole frame is added
  localparam int TMO_CLKS = (`UART_RESP_TIMEOUT_BITS + `UART_FRAME_BITS) * CLKS_PER_BIT;
  localparam int CNT_MAX  = (TMO_CLKS > GAP_CLKS) ? TMO_CLKS : GAP_CLKS;
  localparam int CNT_W    = $clog2(CNT_MAX + 1);

  // The first idle cycle seen in SEND_ADDR, the state change into GAP and the
  // handshake cycle in SEND_DATA also count toward the gap
  localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(GAP_CLKS - 3);
  localparam logic [CNT_W-1:0] TMO_LAST = CNT_W'(TMO_CLKS - 1);

  uart_pkg::seq_state_t        state;
  uart_pkg::cmd_t              cmd;
  logic                        launched;
  logic                        frame_done;
  logic [CNT_W-1:0]            cnt;
  logic [`UART_DATA_WIDTH-1:0] rd_data;
  logic                        rd_err;

  assign cmd_rdy  = (state == uart_pkg::IDLE);
  assign tx_valid = ((state == uart_pkg::SEND_ADDR) || (state == uart_pkg::SEND_DATA)) &&
                    !launched;
  assign tx_byte  = (state == uart_pkg::SEND_DATA) ? cmd.data : {cmd.write, cmd.addr};

  // Serializer went busy after the handshake, so ready again means the stop bit is over
  assign frame_done = launched && tx_ready;

  assign read_rdy  = (state == uart_pkg::REPORT);
  assign read_err  = read_rdy && rd_err;
  assign read_data = rd_data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_pkg::IDLE;
      launched <= 1'b0;
      cnt      <= '0;
    end
    else
    begin
      if (tx_valid && tx_ready)
        launched <= 1'b1;
      else if (frame_done)
        launched <= 1'b0;

      case (state)
        uart_pkg::IDLE:
        begin
          if (cmd_vld)
            state <= uart_pkg::SEND_ADDR;
        end
        uart_pkg::SEND_ADDR:
        begin
          if (frame_done)
          begin
            cnt   <= '0;
            state <= cmd.write ? uart_pkg::GAP : uart_pkg::WAIT_REPLY;
          end
        end
        uart_pkg::GAP:
        begin
          if (cnt == GAP_LAST)
            state <= uart_pkg::SEND_DATA;
          else
            cnt <= cnt + 1'b1;
        end
        uart_pkg::SEND_DATA:
        begin
          if (frame_done)
            state <= uart_pkg::IDLE;
        end
        uart_pkg::WAIT_REPLY:
        begin
          if (rxl.valid || (cnt == TMO_LAST))
            state <= uart_pkg::REPORT;
          else
            cnt <= cnt + 1'b1;
        end
        uart_pkg::REPORT:
          state <= uart_pkg::IDLE;
        default:
          state <= uart_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
      cmd <= uart_pkg::cmd_t'(cmd_in);

    if (state == uart_pkg::WAIT_REPLY)
    begin
      if (rxl.valid)
      begin
        rd_data <= rxl.rx_byte;
        rd_err  <= rxl.parity_err | rxl.stop_err;
      end
      else if (cnt == TMO_LAST)
      begin
        // No reply at all
        rd_data <= '0;
        rd_err  <= 1'b1;
      end
    end
  end

  a_no_accept_while_sending: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> (tx_ready && !tx_valid)
  );

endmodule

//--- verilog/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Command word: write flag, register address, write data
`define UART_CMD_WIDTH 16

// Payload carried by one serial frame
`define UART_DATA_WIDTH 8

// Start, eight data bits, parity and stop
`define UART_FRAME_BITS 11

// Default bit period in system clocks
`define UART_CLKS_PER_BIT 434

// Idle bit-times on tx between the address and data frames of a write
`define UART_GAP_BITS 2

// Bit-times a remote device has to start its reply after a read address frame
`define UART_RESP_TIMEOUT_BITS 64

`endif

//--- verilog/uart_pkg.sv
`include "uart_defs.svh"

package uart_pkg;

  localparam int ADDR_WIDTH = `UART_CMD_WIDTH - `UART_DATA_WIDTH - 1;

  // Overlays the 16-bit command word, MSB first
  typedef struct packed {
    logic                        write;
    logic [ADDR_WIDTH-1:0]       addr;
    logic [`UART_DATA_WIDTH-1:0] data;
  } cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_ADDR,
    GAP,
    SEND_DATA,
    WAIT_REPLY,
    REPORT
  } seq_state_t;

  // Even parity: the parity bit makes the count of ones in the frame even
  function automatic logic even_parity(input logic [`UART_DATA_WIDTH-1:0] value);
    return ^value;
  endfunction

endpackage

//--- verilog/uart_rx_deserializer.sv
`include "uart_defs.svh"

module uart_rx_deserializer #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rx,
  uart_rx_if.rcv rxl
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  // Eight data bits and parity are shifted, the stop bit is checked directly
  localparam logic [3:0] STOP_IDX = 4'(`UART_DATA_WIDTH + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_t;

  rx_state_t                 state;
  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_prev;
  logic                      fall;
  logic [CNT_W-1:0]          clk_cnt;
  logic [3:0]                bit_cnt;
  logic [`UART_DATA_WIDTH:0] shreg;
  logic                      stop_sample;

  assign fall        = rx_prev && !rx_sync;
  assign stop_sample = (state == RX_BITS) && (clk_cnt == BIT_LAST) && (bit_cnt == STOP_IDX);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= RX_IDLE;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
      rxl.valid <= 1'b0;
    end
    else
    begin
      rxl.valid <= stop_sample;
      case (state)
        RX_IDLE:
        begin
          if (fall)
          begin
            state   <= RX_START;
            clk_cnt <= '0;
          end
        end
        RX_START:
        begin
          // A start bit that is gone by mid-bit was only a glitch
          if (clk_cnt == HALF_LAST)
          begin
            state   <= rx_sync ? RX_IDLE : RX_BITS;
            clk_cnt <= '0;
            bit_cnt <= '0;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        RX_BITS:
        begin
          if (clk_cnt == BIT_LAST)
          begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == STOP_IDX)
              state <= RX_IDLE;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == RX_BITS) && (clk_cnt == BIT_LAST) && (bit_cnt != STOP_IDX))
      shreg <= {rx_sync, shreg[`UART_DATA_WIDTH:1]};

    if (stop_sample)
    begin
      rxl.rx_byte    <= shreg[`UART_DATA_WIDTH-1:0];
      rxl.parity_err <= uart_pkg::even_parity(shreg[`UART_DATA_WIDTH-1:0]) !=
                        shreg[`UART_DATA_WIDTH];
      rxl.stop_err   <= !rx_sync;
    end
  end

  a_valid_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    rxl.valid |=> !rxl.valid
  );

endmodule

//--- verilog/uart_rx_if.sv
`include "uart_defs.svh"

// Received frame result, handed from the deserializer to the sequencer
interface uart_rx_if;

  logic [`UART_DATA_WIDTH-1:0] rx_byte;
  logic                        valid;
  logic                        parity_err;
  logic                        stop_err;

  modport rcv (
    output rx_byte,
    output valid,
    output parity_err,
    output stop_err
  );

  // No ready here, a result that arrives outside a read is dropped
  modport seq (
    input rx_byte,
    input valid,
    input parity_err,
    input stop_err
  );

endinterface

//--- verilog/uart_tx_serializer.sv
`include "uart_defs.svh"

module uart_tx_serializer #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_DATA_WIDTH-1:0] tx_byte,
  input  logic                        tx_valid,
  output logic                        tx_ready,
  output logic                        tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [3:0] FRAME_LAST = 4'(`UART_FRAME_BITS - 1);

  logic                        busy;
  logic [CNT_W-1:0]            clk_cnt;
  logic [3:0]                  bit_cnt;
  logic [`UART_FRAME_BITS-1:0] shreg;

  assign tx_ready = !busy;

  // Ones are shifted in behind the frame so the line rests high when idle
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '1;
    end
    else if (!busy)
    begin
      if (tx_valid)
      begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
        // LSB goes out first, start bit at the bottom
        shreg   <= {1'b1, uart_pkg::even_parity(tx_byte), tx_byte, 1'b0};
      end
    end
    else if (clk_cnt == BIT_LAST)
    begin
      clk_cnt <= '0;
      shreg   <= {1'b1, shreg[`UART_FRAME_BITS-1:1]};
      if (bit_cnt == FRAME_LAST)
        busy <= 1'b0;
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
    else
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_ready |-> tx
  );

endmodule
